// File: flist.f
+incdir+design
design/bus_pkg.sv
design/bus_host.sv
design/bus_ram.sv
design/bus_timer.sv
design/irq_arbiter.sv
design/bus_system.sv
tb/tb_bus_system.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_bus_system
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST)) design/bus_cfg.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Output goes to the terminal and is searched for the pass line
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/bus_stim.txt
# Columns: opcode address value, all hex
# 0 write, 1 read and compare, 2 take interrupt id, 3 idle cycles, 4 read at most, 5 read same
0 00 a5
0 3f 5a
0 15 c3
0 2a 3c
1 3f 5a
1 00 a5
1 2a 3c
1 15 c3
0 16 11
1 15 c3
1 16 11
1 40 00
1 80 00
1 ef 00
1 f3 00
0 f0 5a
1 f0 5a
1 f2 5a
0 f1 01
1 f1 01
0 f1 00
1 f1 00
0 f4 30
0 f5 01
3 00 10
0 f5 00
4 f6 30
5 f6 00
0 f0 40
0 f1 01
2 00 00
0 f1 00
0 f4 40
0 f5 01
2 00 01
0 f5 00
0 f8 40
0 f9 01
2 00 02
0 f9 00
0 fc 40
0 fd 01
2 00 03
0 fd 00
0 f4 02
0 f8 02
0 fc 02
0 fd 01
3 00 08
0 f9 01
0 f5 01
3 00 10
0 f5 00
0 f9 00
0 fd 00
2 00 03
2 00 01
2 00 02

// File: tb/tb_bus_system.sv
`timescale 1ns/1ps

`include "bus_cfg.svh"

module tb_bus_system;

  localparam int CMD_TIMEOUT = 50;
  localparam int IRQ_TIMEOUT = 1000;
  localparam int RAND_OPS    = 16;
  localparam int RAM_AW      = $clog2(`BUS_RAM_WORDS);

  logic              CLK;
  logic              rst;
  logic              cmd_req;
  bus_pkg::bus_cmd_t cmd;
  logic              cmd_ack;
  bus_pkg::bus_rsp_t rsp;
  logic              irq_req;
  bus_pkg::irq_msg_t irq;
  logic              irq_ack;

  // Stimulus file state
  integer            fd;
  integer            n_fields;
  logic [8*128-1:0]  line_buf;
  logic [31:0]       op;
  logic [31:0]       addr;
  logic [31:0]       val;
  bit                at_eof;

  // Random phase
  integer             seed;
  logic [31:0]        rnd;
  bus_pkg::bus_data_t rd;
  bus_pkg::bus_data_t last_rd;
  bus_pkg::bus_data_t model [`BUS_RAM_WORDS];
  logic [RAM_AW-1:0]  ofs_list [RAND_OPS];

  bus_system uut (
    .CLK     (CLK),
    .rst     (rst),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp     (rsp),
    .irq_req (irq_req),
    .irq     (irq),
    .irq_ack (irq_ack)
  );

  // 10 ns clock
  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Failure and compare helpers

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string what, input bus_pkg::bus_data_t got,
                             input bus_pkg::bus_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Error at %0t ns: %s, got 0x%02h, expected 0x%02h",
                         $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Command port, one full four-phase handshake

  task automatic bus_access(input logic we, input bus_pkg::bus_addr_t a,
                            input bus_pkg::bus_data_t wdata,
                            output bus_pkg::bus_data_t rdata);
    int n;
    @(posedge CLK);
    cmd     <= {we, a, wdata};
    cmd_req <= 1'b1;
    n = 0;
    // Phase 2, ack with valid response
    do begin
      @(posedge CLK);
      n++;
      if (n > CMD_TIMEOUT) stop_run("Timed out waiting for cmd_ack to rise");
    end while (!cmd_ack);
    rdata = rsp.rdata;
    cmd_req <= 1'b0;
    n = 0;
    // Phase 4, ack released
    do begin
      @(posedge CLK);
      n++;
      if (n > CMD_TIMEOUT) stop_run("Timed out waiting for cmd_ack to fall");
    end while (cmd_ack);
  endtask

  task automatic write_reg(input bus_pkg::bus_addr_t a, input bus_pkg::bus_data_t d);
    bus_pkg::bus_data_t unused;
    bus_access(1'b1, a, d, unused);
  endtask

  task automatic read_reg(input bus_pkg::bus_addr_t a, output bus_pkg::bus_data_t d);
    bus_access(1'b0, a, 8'h00, d);
  endtask

  ////////////////////////////////////////
  // Interrupt port, TB acts as the acknowledger

  task automatic take_irq(input bus_pkg::irq_id_t exp_id);
    int n;
    n = 0;
    do begin
      @(posedge CLK);
      n++;
      if (n > IRQ_TIMEOUT) stop_run("Timed out waiting for irq_req to rise");
    end while (!irq_req);
    check_value("interrupt index", bus_pkg::bus_data_t'(irq.id),
                bus_pkg::bus_data_t'(exp_id));
    irq_ack <= 1'b1;
    n = 0;
    do begin
      @(posedge CLK);
      n++;
      if (n > IRQ_TIMEOUT) stop_run("Timed out waiting for irq_req to fall");
    end while (irq_req);
    irq_ack <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  // One line of the stim file
  task automatic run_op(input logic [31:0] code, input logic [31:0] a,
                        input logic [31:0] v);
    bus_pkg::bus_data_t d;
    case (code)
      0: write_reg(a[7:0], v[7:0]);
      1: begin
        read_reg(a[7:0], d);
        check_value($sformatf("read of 0x%02h", a[7:0]), d, v[7:0]);
      end
      2: take_irq(v[1:0]);
      3: idle_cycles(int'(v));
      // Count must not exceed the reload value
      4: begin
        read_reg(a[7:0], d);
        check_value("count within reload", bus_pkg::bus_data_t'(d <= v[7:0]), 8'h01);
        last_rd = d;
      end
      // Stopped timer holds its count
      5: begin
        read_reg(a[7:0], d);
        check_value("repeated count read", d, last_rd);
      end
      default: stop_run($sformatf("Unknown opcode %0h in the stimulus file", code));
    endcase
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    CLK     = 1'b0;
    rst     = 1'b1;
    cmd_req = 1'b0;
    cmd     = '0;
    irq_ack = 1'b0;
    seed    = 63;
    last_rd = '0;
    repeat (5) @(posedge CLK);
    rst <= 1'b0;

    fd = $fopen("tb/bus_stim.txt", "r");
    if (fd == 0) stop_run("Could not open the stimulus file tb/bus_stim.txt");
    at_eof = 1'b0;
    while (!at_eof) begin
      line_buf = '0;
      if ($fgets(line_buf, fd) == 0) begin
        at_eof = 1'b1;
      end else begin
        // Comment and blank lines give fewer fields
        n_fields = $sscanf(line_buf, "%h %h %h", op, addr, val);
        if (n_fields == 3) run_op(op, addr, val);
      end
    end
    $fclose(fd);

    // Random RAM writes, later writes to one word win
    for (int i = 0; i < RAND_OPS; i++) begin
      rnd = $random(seed);
      ofs_list[i] = rnd[RAM_AW-1:0];
      model[rnd[RAM_AW-1:0]] = rnd[15:8];
      write_reg(bus_pkg::bus_addr_t'(`BUS_RAM_BASE + rnd[RAM_AW-1:0]), rnd[15:8]);
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      read_reg(bus_pkg::bus_addr_t'(`BUS_RAM_BASE + ofs_list[i]), rd);
      check_value("random RAM readback", rd, model[ofs_list[i]]);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: design/bus_system.sv
`timescale 1ns/1ps

`include "bus_cfg.svh"

module bus_system (
  input  logic              CLK,
  input  logic              rst,
  // Command port
  input  logic              cmd_req,
  input  bus_pkg::bus_cmd_t cmd,
  output logic              cmd_ack,
  output bus_pkg::bus_rsp_t rsp,
  // Interrupt port
  output logic              irq_req,
  output bus_pkg::irq_msg_t irq,
  input  logic              irq_ack
);

  ////////////////////////////////////////
  // Shared bus

  bus_pkg::bus_addr_t bus_addr;
  bus_pkg::bus_data_t bus_wdata;
  logic               bus_we;

  // Read words back to the host
  bus_pkg::bus_data_t                       ram_rdata;
  bus_pkg::bus_data_t [`BUS_NUM_TIMERS-1:0] timer_rdata;

  // Timer interrupt pairs
  logic [`BUS_NUM_TIMERS-1:0] irq_raise;
  logic [`BUS_NUM_TIMERS-1:0] irq_clear;

  ////////////////////////////////////////
  // Bus master

  bus_host u_host (
    .CLK         (CLK),
    .rst         (rst),
    .cmd_req     (cmd_req),
    .cmd         (cmd),
    .cmd_ack     (cmd_ack),
    .rsp         (rsp),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_we      (bus_we),
    .ram_rdata   (ram_rdata),
    .timer_rdata (timer_rdata)
  );

  ////////////////////////////////////////
  // Peripherals

  bus_ram u_ram (
    .CLK       (CLK),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_we    (bus_we),
    .rdata     (ram_rdata)
  );

  // One timer per window above the timer base
  for (genvar i = 0; i < `BUS_NUM_TIMERS; i++) begin : g_timer
    bus_timer #(
      .index (i)
    ) u_timer (
      .CLK       (CLK),
      .rst       (rst),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_we    (bus_we),
      .rdata     (timer_rdata[i]),
      .irq_raise (irq_raise[i]),
      .irq_clear (irq_clear[i])
    );
  end

  ////////////////////////////////////////
  // Interrupt collection

  irq_arbiter u_arbiter (
    .CLK       (CLK),
    .rst       (rst),
    .irq_raise (irq_raise),
    .irq_clear (irq_clear),
    .irq_req   (irq_req),
    .irq       (irq),
    .irq_ack   (irq_ack)
  );

endmodule

// File: design/irq_arbiter.sv
`timescale 1ns/1ps

`include "bus_cfg.svh"

module irq_arbiter (
  input  logic                        CLK,
  input  logic                        rst,
  // Timer side
  input  logic [`BUS_NUM_TIMERS-1:0]  irq_raise,
  output logic [`BUS_NUM_TIMERS-1:0]  irq_clear,
  // Outside interrupt port
  output logic                        irq_req,
  output bus_pkg::irq_msg_t           irq,
  input  logic                        irq_ack
);

  bus_pkg::arb_state_t state;
  bus_pkg::irq_id_t    pick;
  bus_pkg::irq_id_t    sel;

  // Lowest pending index wins
  always_comb begin
    pick = '0;
    for (int i = `BUS_NUM_TIMERS - 1; i >= 0; i--) begin
      if (irq_raise[i]) begin
        pick = bus_pkg::irq_id_t'(i);
      end
    end
  end

  ////////////////////////////////////////
  // Interrupt port FSM

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= bus_pkg::arb_idle;
    end else begin
      case (state)
        bus_pkg::arb_idle: begin
          if (|irq_raise) begin
            state <= bus_pkg::arb_request;
          end
        end
        // Ack clears the source and drops the request
        bus_pkg::arb_request: begin
          if (irq_ack) begin
            state <= bus_pkg::arb_release;
          end
        end
        // Wait out the ack
        bus_pkg::arb_release: begin
          if (!irq_ack) begin
            state <= bus_pkg::arb_idle;
          end
        end
        default: begin
          state <= bus_pkg::arb_idle;
        end
      endcase
    end
  end

  // Selection frozen outside idle
  always_ff @(posedge CLK) begin
    if (state == bus_pkg::arb_idle && (|irq_raise)) begin
      sel <= pick;
    end
  end

  assign irq_req = (state == bus_pkg::arb_request);
  assign irq.id  = sel;

  // One-cycle clear toward the selected timer
  always_comb begin
    irq_clear = '0;
    if (state == bus_pkg::arb_request && irq_ack) begin
      irq_clear[sel] = 1'b1;
    end
  end

  // Clear is one-hot and only reaches a pending timer
  a_clear_onehot : assert property (
    @(posedge CLK) disable iff (rst)
      $onehot0(irq_clear) && ((irq_clear & ~irq_raise) == '0)
  );

endmodule

// File: design/bus_timer.sv
`timescale 1ns/1ps

`include "bus_cfg.svh"

module bus_timer #(
  parameter int index = 0
) (
  input  logic               CLK,
  input  logic               rst,
  input  bus_pkg::bus_addr_t bus_addr,
  input  bus_pkg::bus_data_t bus_wdata,
  input  logic               bus_we,
  output bus_pkg::bus_data_t rdata,
  output logic               irq_raise,
  input  logic               irq_clear
);

  // Window base for this instance
  localparam bus_pkg::bus_addr_t BASE =
    bus_pkg::bus_addr_t'(`BUS_TIMER_BASE + `BUS_TIMER_SPAN * index);

  bus_pkg::bus_data_t reload;
  bus_pkg::bus_data_t count;
  logic               enable;

  bus_pkg::bus_addr_t rel;
  logic               in_win;
  logic [1:0]         reg_ofs;
  logic               wr_reload;
  logic               wr_ctrl;
  logic               fire;

  ////////////////////////////////////////
  // Address decode

  assign rel       = bus_addr - BASE;
  assign in_win    = (rel < `BUS_TIMER_SPAN);
  assign reg_ofs   = rel[1:0];
  assign wr_reload = bus_we && in_win && (reg_ofs == `BUS_TIMER_RELOAD_OFS);
  assign wr_ctrl   = bus_we && in_win && (reg_ofs == `BUS_TIMER_CTRL_OFS);

  // Terminal count while running
  assign fire = enable && (count == '0) && !wr_reload;

  ////////////////////////////////////////
  // Counter and control

  always_ff @(posedge CLK) begin
    if (rst) begin
      reload <= '0;
      count  <= '0;
      enable <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        enable <= bus_wdata[0];
      end
      // Reload write also restarts the count
      if (wr_reload) begin
        reload <= bus_wdata;
        count  <= bus_wdata;
      end else if (fire) begin
        count <= reload;
      end else if (enable) begin
        count <= count - 1'b1;
      end
    end
  end

  // Sticky flag, set wins over clear
  always_ff @(posedge CLK) begin
    if (rst) begin
      irq_raise <= 1'b0;
    end else if (fire) begin
      irq_raise <= 1'b1;
    end else if (irq_clear) begin
      irq_raise <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Readback

  always_ff @(posedge CLK) begin
    if (!in_win) begin
      rdata <= '0;
    end else begin
      case (reg_ofs)
        `BUS_TIMER_RELOAD_OFS: rdata <= reload;
        `BUS_TIMER_CTRL_OFS:   rdata <= {7'b0, enable};
        `BUS_TIMER_COUNT_OFS:  rdata <= count;
        default:               rdata <= '0;
      endcase
    end
  end

  // Clear from the arbiter lasts one cycle
  a_clear_pulse : assert property (
    @(posedge CLK) disable iff (rst) irq_clear |=> !irq_clear
  );

endmodule

// File: design/bus_ram.sv
`timescale 1ns/1ps

`include "bus_cfg.svh"

module bus_ram (
  input  logic               CLK,
  input  bus_pkg::bus_addr_t bus_addr,
  input  bus_pkg::bus_data_t bus_wdata,
  input  logic               bus_we,
  output bus_pkg::bus_data_t rdata
);

  localparam int AW = $clog2(`BUS_RAM_WORDS);

  bus_pkg::bus_data_t mem [`BUS_RAM_WORDS];

  bus_pkg::bus_addr_t rel;
  logic               in_win;
  logic [AW-1:0]      ofs;

  // Offset from the window base
  // Addresses below the base wrap high and miss
  assign rel    = bus_addr - `BUS_RAM_BASE;
  assign in_win = (rel < `BUS_RAM_WORDS);
  assign ofs    = rel[AW-1:0];

  // Byte write inside the window
  always_ff @(posedge CLK) begin
    if (bus_we && in_win) begin
      mem[ofs] <= bus_wdata;
    end
  end

  // Registered read port
  always_ff @(posedge CLK) begin
    if (in_win) begin
      rdata <= mem[ofs];
    end else begin
      rdata <= '0;
    end
  end

endmodule

// File: design/bus_host.sv
`timescale 1ns/1ps

`include "bus_cfg.svh"

module bus_host (
  input  logic                                      CLK,
  input  logic                                      rst,
  // Outside command port
  input  logic                                      cmd_req,
  input  bus_pkg::bus_cmd_t                         cmd,
  output logic                                      cmd_ack,
  output bus_pkg::bus_rsp_t                         rsp,
  // Shared bus
  output bus_pkg::bus_addr_t                        bus_addr,
  output bus_pkg::bus_data_t                        bus_wdata,
  output logic                                      bus_we,
  // Read words from the peripherals
  input  bus_pkg::bus_data_t                        ram_rdata,
  input  bus_pkg::bus_data_t [`BUS_NUM_TIMERS-1:0]  timer_rdata
);

  bus_pkg::host_state_t state;
  bus_pkg::bus_cmd_t    cmd_q;
  bus_pkg::bus_data_t   rd_or;

  ////////////////////////////////////////
  // Handshake FSM

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= bus_pkg::host_idle;
      cmd_ack <= 1'b0;
    end else begin
      case (state)
        // Wait for a request
        bus_pkg::host_idle: begin
          if (cmd_req) begin
            state <= bus_pkg::host_issue;
          end
        end
        // One bus cycle
        bus_pkg::host_issue: begin
          state <= bus_pkg::host_capture;
        end
        // Registered read words now valid
        bus_pkg::host_capture: begin
          cmd_ack <= 1'b1;
          state   <= bus_pkg::host_done;
        end
        // Hold ack until the request drops
        bus_pkg::host_done: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= bus_pkg::host_idle;
          end
        end
        default: begin
          state <= bus_pkg::host_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Command and response registers

  always_ff @(posedge CLK) begin
    // Latch the command as the request is taken
    if (state == bus_pkg::host_idle && cmd_req) begin
      cmd_q <= cmd;
    end
    if (state == bus_pkg::host_capture) begin
      rsp.rdata <= rd_or;
    end
  end

  // Unaddressed peripherals return zero
  always_comb begin
    rd_or = ram_rdata;
    for (int i = 0; i < `BUS_NUM_TIMERS; i++) begin
      rd_or = rd_or | timer_rdata[i];
    end
  end

  // Bus outputs
  assign bus_addr  = cmd_q.addr;
  assign bus_wdata = cmd_q.wdata;
  // Write strobe only in the issue state
  assign bus_we    = (state == bus_pkg::host_issue) && cmd_q.we;

  // Outside must keep the request up until the ack arrives
  a_ack_needs_req : assert property (
    @(posedge CLK) disable iff (rst) $rose(cmd_ack) |-> cmd_req
  );

endmodule

// File: design/bus_pkg.sv
package bus_pkg;

  ////////////////////////////////////////
  // Plain vector types

  typedef logic [7:0] bus_addr_t;
  typedef logic [7:0] bus_data_t;

  // Timer index on the interrupt port
  typedef logic [1:0] irq_id_t;

  ////////////////////////////////////////
  // Port bundles

  // Host command, 17 bits
  typedef struct packed {
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_cmd_t;

  // Host response
  typedef struct packed {
    bus_data_t rdata;
  } bus_rsp_t;

  // Interrupt message to the outside
  typedef struct packed {
    irq_id_t id;
  } irq_msg_t;

  ////////////////////////////////////////
  // FSM states

  typedef enum logic [1:0] {host_idle, host_issue, host_capture, host_done} host_state_t;

  typedef enum logic [1:0] {arb_idle, arb_request, arb_release} arb_state_t;

endpackage

// File: design/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Number of interval timers on the bus
`define BUS_NUM_TIMERS 4

// RAM window
`define BUS_RAM_BASE 8'h00
`define BUS_RAM_WORDS 64

// Timer windows, four addresses per timer
`define BUS_TIMER_BASE 8'hF0
`define BUS_TIMER_SPAN 4

// Register offsets inside a timer window
`define BUS_TIMER_RELOAD_OFS 2'd0
`define BUS_TIMER_CTRL_OFS 2'd1
`define BUS_TIMER_COUNT_OFS 2'd2

`endif
